// ==== build.f ====
nibble_pkg.sv
nibble_apb_cmd.sv
nibble_seq.sv
nibble_regs.sv
nibble_alu.sv
nibble_csr.sv
nibble_result.sv
nibble_exec_top.sv
tb_nibble_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the nibble execution testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_nibble_exec \
    -f build.f -o tb_nibble_exec > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/tb_nibble_exec > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "RESULT: FAIL" "$SIM_LOG" && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" "$SIM_LOG" && echo "Simulation passed" && exit 0
echo "Simulation ended without a result"
exit 1

// ==== tb_nibble_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_nibble_exec;
    import nibble_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int DRIVE_DLY  = 1;
    localparam int NUM_OPS    = 73;   // Operations issued over all tests
    localparam int STALL_MAX  = 40;   // Cycles before a bus or busy wait gives up

    logic        clk;
    logic        rstn;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;

    // Reference model state
    logic [31:0] model_regs [16];
    logic [31:0] model_scratch;
    int          model_instret;

    logic [31:0] rng;
    time         accept_time;    // Edge that completed the last APB write
    int          err_count;
    int          check_count;
    int          mark_err;
    int          mark_chk;

    // Check channels, held across one rising edge
    logic        val_en;
    logic [31:0] val_exp;
    logic [31:0] val_act;
    logic        cond_en;
    logic        cond_ok;
    string       chk_name;
    string       chk_msg;

    nibble_exec_top #(.NUM_REGS(16)) uut (
        .clk(clk), .rstn(rstn),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    a_value: assert property (@(posedge clk) val_en |-> val_act == val_exp)
        else begin
            $display("Mismatch in %s: expected %h, actual %h", chk_name, val_exp, val_act);
            err_count++;
        end

    a_cond: assert property (@(posedge clk) cond_en |-> cond_ok)
        else begin
            $display("Check failed in %s: %s", chk_name, chk_msg);
            err_count++;
        end

    initial begin : watchdog
        #((NUM_OPS * 20 + 500) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic cmd_word_t alu_cmd(input op_t op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2,
                                          input logic use_imm, input logic [11:0] imm12);
        cmd_word_t w;
        w             = '0;
        w.alu.op      = op;
        w.alu.rd      = rd;
        w.alu.rs1     = rs1;
        w.alu.rs2     = rs2;
        w.alu.use_imm = use_imm;
        w.alu.imm12   = imm12;
        return w;
    endfunction

    function automatic cmd_word_t csr_cmd(input op_t op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [11:0] addr);
        cmd_word_t w;
        w              = '0;
        w.csr.op       = op;
        w.csr.rd       = rd;
        w.csr.rs1      = rs1;
        w.csr.csr_addr = addr;
        return w;
    endfunction

    // Value the operation should leave in RESULT
    function automatic logic [31:0] expected_result(input cmd_word_t c);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[c.alu.rs1];
        b = c.alu.use_imm ? sext12(c.alu.imm12) : model_regs[c.alu.rs2];
        case (c.alu.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_LI:   return sext12(c.alu.imm12);
            OP_CSRR: begin
                if (c.csr.csr_addr == CSR_MINSTRET) return 32'(model_instret + 1);
                if (c.csr.csr_addr == CSR_MSCRATCH) return model_scratch;
                return 32'd0;   // mcycle is checked by ordering only
            end
            OP_CSRW: return a;
            default: return 32'd0;
        endcase
    endfunction

    task automatic commit_model(input cmd_word_t c, input logic [31:0] value);
        if (c.csr.op == OP_CSRW) begin
            if (c.csr.csr_addr == CSR_MSCRATCH) begin
                model_scratch = model_regs[c.csr.rs1];
            end
        end else if (c.alu.rd != 4'd0) begin
            model_regs[c.alu.rd] = value;
        end
        model_instret++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        chk_name = name;
        val_exp  = exp;
        val_act  = act;
        val_en   = 1'b1;
        check_count++;
        @(posedge clk);
        #DRIVE_DLY;
        val_en = 1'b0;
    endtask

    task automatic check_true(input string name, input logic ok, input string msg);
        chk_name = name;
        chk_msg  = msg;
        cond_ok  = ok;
        cond_en  = 1'b1;
        check_count++;
        @(posedge clk);
        #DRIVE_DLY;
        cond_en = 1'b0;
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output int waits, output logic ok, output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < STALL_MAX) begin   // Back-pressure
            waits++;
            @(negedge clk);
        end
        ok    = pready;
        err   = pslverr;
        rdata = prdata;
        @(posedge clk);
        if (write) begin
            accept_time = $time;
        end
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input string name, input logic [11:0] addr,
                             input logic [31:0] data, input logic expect_err,
                             output int waits);
        logic [31:0] unused;
        logic        ok;
        logic        err;
        apb_transfer(1'b1, addr, data, unused, waits, ok, err);
        check_true({name, " write"}, ok && err == expect_err,
                   "APB write stalled or returned the wrong pslverr");
    endtask

    task automatic apb_read(input string name, input logic [11:0] addr,
                            input logic expect_err, output logic [31:0] data);
        int   waits;
        logic ok;
        logic err;
        apb_transfer(1'b0, addr, 32'd0, data, waits, ok, err);
        check_true({name, " read"}, ok && err == expect_err,
                   "APB read stalled or returned the wrong pslverr");
    endtask

    // Busy must drop exactly nine edges after the accepting edge
    task automatic wait_idle(input string name);
        int   n;
        logic seen;
        time  fall_edge;
        n    = 0;
        seen = 1'b0;
        while (n < STALL_MAX) begin
            @(negedge clk);
            if (uut.busy) begin
                seen = 1'b1;
            end else if (seen) begin
                break;
            end
            n++;
        end
        fall_edge = $time - CLK_PERIOD / 2;
        check_value({name, " latency"}, 32'd9, 32'((fall_edge - accept_time) / CLK_PERIOD));
    endtask

    task automatic run_op(input string name, input cmd_word_t c, input logic check_res,
                          output logic [31:0] act);
        logic [31:0] exp;
        int          waits;
        exp = expected_result(c);
        apb_write(name, ADDR_CMD, c, 1'b0, waits);
        wait_idle(name);
        apb_read(name, ADDR_RESULT, 1'b0, act);
        if (check_res) begin
            check_value(name, exp, act);
        end
        commit_model(c, check_res ? exp : act);
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished: %0d checks, %0d errors", name,
                 check_count - mark_chk, err_count - mark_err);
        mark_chk = check_count;
        mark_err = err_count;
    endtask

    task automatic test_reset();
        logic [31:0] data;
        int          waits;
        apb_read("reset status", ADDR_STATUS, 1'b0, data);
        check_value("reset status", 32'd0, data);
        apb_read("reset result", ADDR_RESULT, 1'b0, data);
        check_value("reset result", 32'd0, data);
        run_op("reset minstret", csr_cmd(OP_CSRR, 4'd1, 4'd0, CSR_MINSTRET), 1'b1, data);
        run_op("reset mscratch", csr_cmd(OP_CSRR, 4'd2, 4'd0, CSR_MSCRATCH), 1'b1, data);
        apb_read("unmapped", 12'h010, 1'b1, data);
        apb_write("unmapped", 12'h010, 32'h1234_5678, 1'b1, waits);
        check_true("unmapped", waits == 0, "write to an unmapped offset was stalled");
        apb_write("result offset", ADDR_RESULT, 32'h1, 1'b1, waits);
        end_test("reset_state");
    endtask

    task automatic test_reg_ops();
        logic [31:0] r;
        logic [31:0] data;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            run_op($sformatf("li_%0d", i),
                   alu_cmd(OP_LI, 4'(1 + r[15:12] % 15), 4'd0, 4'd0, 1'b0, r[11:0]), 1'b1, data);
        end
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            run_op($sformatf("rr_%0d", i),
                   alu_cmd(op_t'(4'(r % 32'd5)), r[11:8], r[15:12], r[19:16], 1'b0, 12'd0),
                   1'b1, data);
        end
        end_test("reg_reg_ops");
    endtask

    task automatic test_imm_x0();
        logic [31:0] r;
        logic [31:0] data;
        for (int i = 0; i < 7; i++) begin
            r = next_rand();
            // Bit 11 set so every immediate is negative
            run_op($sformatf("imm_neg_%0d", i),
                   alu_cmd(op_t'(4'(i)), 4'(5 + i), r[19:16], 4'd0, 1'b1, {1'b1, r[10:0]}),
                   1'b1, data);
        end
        run_op("x0 seed", alu_cmd(OP_LI, 4'd3, 4'd0, 4'd0, 1'b0, 12'h5a5), 1'b1, data);
        run_op("x0 add", alu_cmd(OP_ADD, 4'd0, 4'd3, 4'd3, 1'b0, 12'd0), 1'b1, data);
        run_op("x0 li", alu_cmd(OP_LI, 4'd0, 4'd0, 4'd0, 1'b0, 12'h7ff), 1'b1, data);
        run_op("x0 read", alu_cmd(OP_ADD, 4'd4, 4'd0, 4'd0, 1'b0, 12'd0), 1'b1, data);
        run_op("x0 pass", alu_cmd(OP_ADD, 4'd4, 4'd0, 4'd3, 1'b0, 12'd0), 1'b1, data);
        end_test("imm_and_x0");
    endtask

    task automatic test_compare();
        logic [31:0] r;
        logic [31:0] data;
        logic [3:0]  pa [6];
        logic [3:0]  pb [6];
        pa = '{4'd1, 4'd2, 4'd2, 4'd1, 4'd7, 4'd8};
        pb = '{4'd2, 4'd1, 4'd3, 4'd1, 4'd8, 4'd7};
        r  = next_rand();
        run_op("cmp r1", alu_cmd(OP_LI, 4'd1, 4'd0, 4'd0, 1'b0, 12'hffb), 1'b1, data);
        run_op("cmp r2", alu_cmd(OP_LI, 4'd2, 4'd0, 4'd0, 1'b0, 12'h003), 1'b1, data);
        run_op("cmp r3", alu_cmd(OP_LI, 4'd3, 4'd0, 4'd0, 1'b0, 12'h003), 1'b1, data);
        run_op("cmp r7", alu_cmd(OP_LI, 4'd7, 4'd0, 4'd0, 1'b0, r[11:0]), 1'b1, data);
        run_op("cmp r8", alu_cmd(OP_LI, 4'd8, 4'd0, 4'd0, 1'b0, {~r[11], r[22:12]}),
               1'b1, data);
        for (int i = 0; i < 6; i++) begin
            run_op($sformatf("slt_%0d", i),
                   alu_cmd(OP_SLT, 4'd9, pa[i], pb[i], 1'b0, 12'd0), 1'b1, data);
            run_op($sformatf("sltu_%0d", i),
                   alu_cmd(OP_SLTU, 4'd10, pa[i], pb[i], 1'b0, 12'd0), 1'b1, data);
        end
        run_op("slti", alu_cmd(OP_SLT, 4'd9, 4'd2, 4'd0, 1'b1, 12'hff0), 1'b1, data);
        run_op("sltiu", alu_cmd(OP_SLTU, 4'd10, 4'd2, 4'd0, 1'b1, 12'hff0), 1'b1, data);
        end_test("compare");
    endtask

    task automatic test_csr();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] first;
        logic [31:0] second;
        r = next_rand();
        run_op("scratch src", alu_cmd(OP_LI, 4'd9, 4'd0, 4'd0, 1'b0, r[11:0]), 1'b1, data);
        run_op("csrw mscratch", csr_cmd(OP_CSRW, 4'd0, 4'd9, CSR_MSCRATCH), 1'b0, data);
        run_op("csrr mscratch", csr_cmd(OP_CSRR, 4'd10, 4'd0, CSR_MSCRATCH), 1'b1, data);
        run_op("csrr minstret", csr_cmd(OP_CSRR, 4'd11, 4'd0, CSR_MINSTRET), 1'b1, data);
        run_op("mcycle first", csr_cmd(OP_CSRR, 4'd12, 4'd0, CSR_MCYCLE), 1'b0, first);
        run_op("mcycle second", csr_cmd(OP_CSRR, 4'd12, 4'd0, CSR_MCYCLE), 1'b0, second);
        check_true("mcycle", second > first, "second mcycle read is not above the first");
        run_op("csrw unknown", csr_cmd(OP_CSRW, 4'd0, 4'd9, 12'h7c0), 1'b0, data);
        run_op("csrr unknown", csr_cmd(OP_CSRR, 4'd13, 4'd0, 12'h7c0), 1'b1, data);
        end_test("csr");
    endtask

    task automatic test_backpressure();
        cmd_word_t   c1;
        cmd_word_t   c2;
        logic [31:0] exp;
        logic [31:0] data;
        int          waits;
        c1  = alu_cmd(OP_LI, 4'd11, 4'd0, 4'd0, 1'b0, 12'h9c3);
        exp = expected_result(c1);
        apb_write("status op", ADDR_CMD, c1, 1'b0, waits);
        apb_read("status busy", ADDR_STATUS, 1'b0, data);
        check_value("status busy", 32'd1, data);
        wait_idle("status op");
        apb_read("status op", ADDR_RESULT, 1'b0, data);
        check_value("status op", exp, data);
        commit_model(c1, exp);

        // Second CMD write lands while the first is still running
        c1  = alu_cmd(OP_LI, 4'd12, 4'd0, 4'd0, 1'b0, 12'h2d7);
        commit_model(c1, expected_result(c1));
        apb_write("bp first", ADDR_CMD, c1, 1'b0, waits);
        c2  = alu_cmd(OP_ADD, 4'd13, 4'd12, 4'd11, 1'b0, 12'd0);
        exp = expected_result(c2);
        apb_write("bp second", ADDR_CMD, c2, 1'b0, waits);
        commit_model(c2, exp);
        wait_idle("bp second");
        check_true("bp second", waits > 0, "pready was not held low while busy");
        apb_read("bp second", ADDR_RESULT, 1'b0, data);
        check_value("bp second", exp, data);
        run_op("bp first readback", alu_cmd(OP_ADD, 4'd14, 4'd12, 4'd0, 1'b0, 12'd0),
               1'b1, data);
        end_test("backpressure");
    endtask

    initial begin : stimulus
        clk           = 1'b0;
        rstn          = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        val_en        = 1'b0;
        val_exp       = '0;
        val_act       = '0;
        cond_en       = 1'b0;
        cond_ok       = 1'b1;
        chk_name      = "";
        chk_msg       = "";
        rng           = 32'h2937428a;
        accept_time   = 0;
        err_count     = 0;
        check_count   = 0;
        mark_err      = 0;
        mark_chk      = 0;
        model_scratch = '0;
        model_instret = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;

        test_reset();
        test_reg_ops();
        test_imm_x0();
        test_compare();
        test_csr();
        test_backpressure();

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== nibble_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_exec_top #(
    parameter int NUM_REGS = 16
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire [11:0] paddr,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire [31:0] pwdata,
    output wire [31:0] prdata,
    output wire        pready,
    output wire        pslverr
);
    import nibble_pkg::*;

    cmd_word_t       cmd;
    logic            start;
    logic            busy;
    logic            complete;
    logic [2:0]      counter;
    logic [3:0]      data_rs1;
    logic [3:0]      data_rs2;
    logic [3:0]      data_rd;
    logic            wr_en;
    logic [3:0]      csr_nibble;
    logic [XLEN-1:0] result;

    nibble_apb_cmd u_apb (
        .clk(clk), .rstn(rstn),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .busy(busy), .result(result),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd(cmd), .start(start)
    );

    nibble_seq u_seq (
        .clk(clk), .rstn(rstn), .start(start),
        .busy(busy), .counter(counter), .complete(complete)
    );

    nibble_regs #(.NUM_REGS(NUM_REGS)) u_regs (
        .clk(clk), .rstn(rstn), .counter(counter),
        .rs1(cmd.alu.rs1), .rs2(cmd.alu.rs2), .rd(cmd.alu.rd),
        .wr_en(wr_en), .data_rd(data_rd),
        .data_rs1(data_rs1), .data_rs2(data_rs2)
    );

    nibble_alu u_alu (
        .clk(clk), .cmd(cmd), .busy(busy), .counter(counter),
        .data_rs1(data_rs1), .data_rs2(data_rs2), .csr_nibble(csr_nibble),
        .data_rd(data_rd), .wr_en(wr_en)
    );

    nibble_csr u_csr (
        .clk(clk), .rstn(rstn), .cmd(cmd), .busy(busy), .counter(counter),
        .complete(complete), .data_rs1(data_rs1), .csr_nibble(csr_nibble)
    );

    nibble_result u_result (
        .clk(clk), .rstn(rstn), .busy(busy), .data_rd(data_rd),
        .complete(complete), .result(result)
    );

endmodule

`default_nettype wire

// ==== nibble_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_result (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            busy,
    input  wire  [3:0]                     data_rd,
    input  wire                            complete,
    output logic [nibble_pkg::XLEN-1:0]    result
);
    import nibble_pkg::*;

    logic [XLEN-1:0] staging;
    logic            done_q;   // Cycle of the ALU's low-nibble replay

    always_ff @(posedge clk) begin
        if (busy) begin
            staging <= {data_rd, staging[XLEN-1:4]};   // Low nibble arrives first
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= complete;
            if (complete) begin
                result <= {data_rd, staging[XLEN-1:4]};
            end else if (done_q) begin
                result[3:0] <= data_rd;   // Corrected compare nibble
            end
        end
    end

    // RESULT never moves partway through an operation
    a_result_hold: assert property (@(posedge clk) disable iff (!rstn)
        busy && !complete |=> $stable(result));

endmodule

`default_nettype wire

// ==== nibble_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_csr (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire nibble_pkg::cmd_word_t cmd,
    input  wire                        busy,
    input  wire  [2:0]                 counter,
    input  wire                        complete,
    input  wire  [3:0]                 data_rs1,
    output logic [3:0]                 csr_nibble
);
    import nibble_pkg::*;

    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] mcycle_snap;   // Frozen at sub-cycle 0 for a coherent read
    logic [XLEN-1:0] minstret;
    logic [XLEN-1:0] instret_next;
    logic [XLEN-1:0] mscratch;
    logic [4:0]      nib_lsb;
    logic            scratch_wr;

    assign nib_lsb      = {counter, 2'b00};
    assign instret_next = minstret + 1'b1;
    assign scratch_wr   = busy && cmd.csr.op == OP_CSRW && cmd.csr.csr_addr == CSR_MSCRATCH;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mcycle   <= '0;
            minstret <= '0;
            mscratch <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            if (complete) begin
                minstret <= instret_next;
            end
            if (scratch_wr) begin
                mscratch[nib_lsb +: 4] <= data_rs1;   // One nibble per sub-cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && counter == 3'd0) begin
            mcycle_snap <= mcycle;
        end
    end

    always_comb begin
        case (cmd.csr.csr_addr)
            CSR_MCYCLE: begin
                csr_nibble = (counter == 3'd0) ? mcycle[3:0] : mcycle_snap[nib_lsb +: 4];
            end
            CSR_MINSTRET: csr_nibble = instret_next[nib_lsb +: 4];   // Counts this op too
            CSR_MSCRATCH: csr_nibble = mscratch[nib_lsb +: 4];
            default:      csr_nibble = 4'd0;
        endcase
    end

    a_instret_step: assert property (@(posedge clk) disable iff (!rstn)
        complete |=> minstret == $past(minstret) + 1'b1);

    // Snapshot from sub-cycle 0 trails the live counter by one
    a_snap_coherent: assert property (@(posedge clk) disable iff (!rstn)
        busy && counter == 3'd1 |-> mcycle_snap == mcycle - 1'b1);

endmodule

`default_nettype wire

// ==== nibble_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_alu (
    input  wire                   clk,
    input  wire nibble_pkg::cmd_word_t cmd,
    input  wire                   busy,
    input  wire  [2:0]            counter,
    input  wire  [3:0]            data_rs1,
    input  wire  [3:0]            data_rs2,
    input  wire  [3:0]            csr_nibble,
    output logic [3:0]            data_rd,
    output logic                  wr_en
);
    import nibble_pkg::*;

    op_t        op;
    logic       is_sub;
    logic       is_cmp;
    logic       last_nib;
    logic [3:0] imm_nib;
    logic [3:0] opb;
    logic [3:0] opb_eff;
    logic       cy_in;
    logic [4:0] sum;
    logic       cmp_bit;
    logic       cy;        // Carry into the next nibble
    logic       last_q;    // Cycle right after sub-cycle 7
    logic [3:0] lo_hold;   // Low result nibble, replayed once the op ends

    assign op       = cmd.alu.op;
    assign is_sub   = (op == OP_SUB);
    assign is_cmp   = (op == OP_SLT) || (op == OP_SLTU);
    assign last_nib = busy && (counter == 3'(NIBBLES - 1));

    // Nibbles 3 to 7 carry the immediate's sign
    assign imm_nib = (counter[2] || counter[1:0] == 2'b11) ? {4{cmd.alu.imm12[11]}}
                   : cmd.alu.imm12[{counter[1:0], 2'b00} +: 4];

    assign opb     = (cmd.alu.use_imm || op == OP_LI) ? imm_nib : data_rs2;
    assign opb_eff = (is_sub || is_cmp) ? ~opb : opb;
    assign cy_in   = (counter == 3'd0) ? (is_sub || is_cmp) : cy;
    assign sum     = {1'b0, data_rs1} + {1'b0, opb_eff} + {4'd0, cy_in};

    // Signs differ: rs1 sign decides, else the sign of the difference
    assign cmp_bit = (op == OP_SLTU) ? !sum[4]
                   : (data_rs1[3] != opb[3]) ? data_rs1[3] : sum[3];

    always_ff @(posedge clk) begin
        cy     <= sum[4];
        last_q <= last_nib;
        if (busy && counter == 3'd0) begin
            lo_hold <= data_rd;
        end else if (last_nib && is_cmp) begin
            lo_hold <= {3'b000, cmp_bit};   // Compare resolved only now
        end
    end

    always_comb begin
        wr_en   = 1'b0;
        data_rd = lo_hold;
        if (busy) begin
            wr_en = 1'b1;
            case (op)
                OP_ADD, OP_SUB: data_rd = sum[3:0];
                OP_AND:         data_rd = data_rs1 & opb;
                OP_OR:          data_rd = data_rs1 | opb;
                OP_XOR:         data_rd = data_rs1 ^ opb;
                OP_SLT, OP_SLTU: data_rd = 4'd0;   // Low nibble patched afterwards
                OP_LI:          data_rd = imm_nib;
                OP_CSRR:        data_rd = csr_nibble;
                OP_CSRW: begin
                    wr_en   = 1'b0;
                    data_rd = data_rs1;
                end
                default: begin
                    wr_en   = 1'b0;
                    data_rd = 4'd0;
                end
            endcase
        end else begin
            wr_en = last_q && is_cmp;   // Deferred write of the compare bit
        end
    end

    // Only the deferred compare write lands outside an operation
    a_wr_window: assert property (@(posedge clk)
        wr_en && !busy |-> $past(busy) && $past(counter) == 3'(NIBBLES - 1));

endmodule

`default_nettype wire

// ==== nibble_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_regs #(
    parameter int NUM_REGS = 16
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire  [2:0] counter,
    input  wire  [3:0] rs1,
    input  wire  [3:0] rs2,
    input  wire  [3:0] rd,
    input  wire        wr_en,
    input  wire  [3:0] data_rd,
    output logic [3:0] data_rs1,
    output logic [3:0] data_rs2
);
    import nibble_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0]  regs_q [NUM_REGS];
    logic [IDX_W-1:0] rs1_idx;
    logic [IDX_W-1:0] rs2_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [4:0]       nib_lsb;    // Bit offset of the active nibble

    assign nib_lsb = {counter, 2'b00};
    assign rs1_idx = rs1[IDX_W-1:0];
    assign rs2_idx = rs2[IDX_W-1:0];
    assign rd_idx  = rd[IDX_W-1:0];

    assign data_rs1 = regs_q[rs1_idx][nib_lsb +: 4];
    assign data_rs2 = regs_q[rs2_idx][nib_lsb +: 4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en && rd_idx != '0) begin   // x0 stays zero
            regs_q[rd_idx][nib_lsb +: 4] <= data_rd;
        end
    end

    a_rd_range: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> int'(rd) < NUM_REGS);

endmodule

`default_nettype wire

// ==== nibble_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_seq (
    input  wire        clk,
    input  wire        rstn,
    input  wire        start,
    output logic       busy,
    output logic [2:0] counter,
    output logic       complete
);
    import nibble_pkg::*;

    assign complete = busy && (counter == 3'(NIBBLES - 1));  // Last sub-cycle

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            counter <= 3'd0;
        end else if (start) begin
            busy    <= 1'b1;
            counter <= 3'd0;
        end else if (busy) begin
            counter <= counter + 3'd1;   // Wraps back to 0 after sub-cycle 7
            if (complete) begin
                busy <= 1'b0;
            end
        end
    end

    a_count_step: assert property (@(posedge clk) disable iff (!rstn)
        busy && !complete |=> counter == $past(counter) + 3'd1);

    // Every operation runs exactly eight sub-cycles
    a_run_length: assert property (@(posedge clk) disable iff (!rstn)
        start |=> busy && counter == 3'd0 ##7 complete);

endmodule

`default_nettype wire

// ==== nibble_apb_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_apb_cmd (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire  [11:0]                        paddr,
    input  wire                                psel,
    input  wire                                penable,
    input  wire                                pwrite,
    input  wire  [31:0]                        pwdata,
    input  wire                                busy,
    input  wire  [31:0]                        result,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    output nibble_pkg::cmd_word_t              cmd,
    output logic                               start
);
    import nibble_pkg::*;

    logic access;
    logic is_cmd;
    logic is_result;
    logic is_status;
    logic unmapped;
    logic accept;

    assign access    = psel && penable;
    assign is_cmd    = (paddr == ADDR_CMD);
    assign is_result = (paddr == ADDR_RESULT);
    assign is_status = (paddr == ADDR_STATUS);
    assign unmapped  = !(is_cmd || is_result || is_status);

    // Back-pressure on CMD writes until the running operation drains
    assign pready  = psel && !(pwrite && is_cmd && (busy || start));
    assign pslverr = access && (unmapped || (pwrite && (is_result || is_status)));
    assign accept  = access && pwrite && is_cmd && pready;

    always_comb begin
        case (paddr)
            ADDR_RESULT: prdata = result;
            ADDR_STATUS: prdata = {{(XLEN-1){1'b0}}, busy || start};  // Busy in bit 0
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            start <= 1'b0;
            cmd   <= '0;
        end else begin
            start <= accept;   // One-cycle pulse
            if (accept) begin
                cmd <= pwdata;
            end
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy);

    // An accepted command reaches the sequencer two cycles later
    a_accept_runs: assert property (@(posedge clk) disable iff (!rstn)
        accept |=> start ##1 busy);

endmodule

`default_nettype wire

// ==== nibble_pkg.sv ====
`default_nettype none

package nibble_pkg;

    localparam int XLEN    = 32;
    localparam int NIBBLES = 8;     // Sub-cycles per operation

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLTU = 4'd6,
        OP_LI   = 4'd7,
        OP_CSRR = 4'd8,
        OP_CSRW = 4'd9
    } op_t;

    // Register and immediate operations
    typedef struct packed {
        op_t         op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic        use_imm;
        logic [2:0]  rsvd;
        logic [11:0] imm12;
    } cmd_alu_t;

    // CSR operations, csr_addr shares the imm12 bits
    typedef struct packed {
        op_t         op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [7:0]  rsvd;
        logic [11:0] csr_addr;
    } cmd_csr_t;

    typedef union packed {
        cmd_alu_t alu;
        cmd_csr_t csr;
    } cmd_word_t;

    localparam logic [11:0] CSR_MCYCLE   = 12'hC00;
    localparam logic [11:0] CSR_MINSTRET = 12'hC02;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;

    // APB byte offsets
    localparam logic [11:0] ADDR_CMD    = 12'h000;
    localparam logic [11:0] ADDR_RESULT = 12'h004;
    localparam logic [11:0] ADDR_STATUS = 12'h008;

endpackage

`default_nettype wire
